//--- Makefile
# Verilator build and run of the instruction store testbench

TOP := fcore_istore_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f fcore_istore.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) && echo "PASS" || \
		(echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- fcore_istore.f
+incdir+verilog
verilog/istore_pkg.sv
verilog/isa_pkg.sv
verilog/istore_axil_writer.sv
verilog/istore_memory.sv
verilog/fetch_sequencer.sv
verilog/instruction_decoder.sv
verilog/fcore_istore_top.sv
verification/fcore_istore_checker.sv
verification/fcore_istore_tb.sv

//--- verification/fcore_istore_checker.sv
`timescale 1ns/1ps
`include "fcore_consts.svh"

module fcore_istore_checker (
    input  logic                                     clock_in,
    input  logic                                     reset_in,
    input  logic                                     awvalid,
    input  istore_pkg::byte_addr_t                   awaddr,
    input  logic                                     awready,
    input  logic                                     wvalid,
    input  istore_pkg::axi_word_t                    wdata,
    input  logic                                     wready,
    input  logic                                     bvalid,
    input  logic [1:0]                               bresp,
    input  logic                                     bready,
    input  logic                                     run,
    input  logic [$bits(istore_pkg::entry_addr_t):0] program_length,
    input  logic                                     instr_valid,
    input  isa_pkg::opcode_t                         opcode,
    input  isa_pkg::reg_idx_t                        dest,
    input  isa_pkg::reg_idx_t                        src_a,
    input  isa_pkg::reg_idx_t                        src_b,
    input  istore_pkg::axi_word_t                    immediate,
    input  logic                                     illegal,
    input  logic                                     done
);

    logic [31:0] shadow_lo [`ISTORE_DEPTH];  // Even words
    logic [31:0] shadow_hi [`ISTORE_DEPTH];  // Odd words

    string      test_name     = "reset";
    int         data_errors   = 0;
    int         resp_errors   = 0;
    int         seq_errors    = 0;
    int         compared      = 0;
    int         responses     = 0;
    logic       resp_pending  = 1'b0;
    logic [1:0] resp_expected = 2'b00;
    logic       active        = 1'b0;  // From an accepted run up to its done
    int         run_cycle     = 0;
    int         run_length    = 0;

    // Expected {illegal, immediate, src_b, src_a, dest, opcode} from the entry layout
    function automatic logic [55:0] decode_ref(input logic [63:0] e);
        logic bad;
        bad = e[4:0] > 5'd8;  // Only encodings 0 to 8 are opcodes
        return {bad, e[63:32], e[22:17], e[16:11], e[10:5], e[4:0]};
    endfunction

    function automatic int total_errors();
        return data_errors + resp_errors + seq_errors;
    endfunction

    task automatic flag_error(input string what);
        seq_errors++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic report_counts();
        $display("Checker: %0d entries compared, %0d responses, errors data %0d resp %0d seq %0d",
                 compared, responses, data_errors, resp_errors, seq_errors);
    endtask

    // ----------------------------------------
    // Write channels and response
    // ----------------------------------------
    always @(posedge clock_in) begin
        int unsigned word_idx;
        if (!reset_in) begin
            resp_pending = 1'b0;
        end else begin
            if (resp_pending && bvalid !== 1'b1) begin
                resp_errors++;
                $display("Error %s bvalid expected 1 actual %b", test_name, bvalid);
                resp_pending = 1'b0;
            end else if (resp_pending) begin
                if (bresp !== resp_expected) begin
                    resp_errors++;
                    $display("Error %s bresp expected %b actual %b",
                             test_name, resp_expected, bresp);
                end
                if (bready === 1'b1) begin  // Response taken
                    resp_pending = 1'b0;
                    responses++;
                end
            end else if (bvalid !== 1'b0) begin
                resp_errors++;
                $display("Error %s bvalid expected 0 actual %b", test_name, bvalid);
            end

            if (awready !== wready || (awready === 1'b1 && !(awvalid && wvalid))) begin
                resp_errors++;
                $display("%s: write channels were accepted out of step", test_name);
            end else if (awready === 1'b1) begin
                word_idx      = 32'(awaddr) >> 2;
                resp_expected = 2'b00;  // OKAY
                if (word_idx >= 2 * `ISTORE_DEPTH) begin
                    resp_expected = 2'b10;  // SLVERR, store untouched
                end else if (word_idx[0]) begin
                    shadow_hi[word_idx[8:1]] = wdata;
                end else begin
                    shadow_lo[word_idx[8:1]] = wdata;
                end
                resp_pending = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Decoded stream
    // ----------------------------------------
    always @(posedge clock_in) begin
        logic        exp_valid;
        logic        exp_done;
        logic [63:0] e;
        if (!reset_in) begin
            active = 1'b0;
        end else begin
            if (!active && run === 1'b1) begin
                active     = 1'b1;
                run_cycle  = 0;
                run_length = int'(program_length);
            end
            // Issue starts the cycle after the run, output lags issue by two
            exp_valid = active && run_cycle >= 3 && run_cycle < 3 + run_length;
            exp_done  = active && run_cycle == 2 + ((run_length == 0) ? 1 : run_length);
            if (instr_valid !== exp_valid || done !== exp_done) begin
                seq_errors++;
                $display("Error %s valid,done at run cycle %0d expected %b%b actual %b%b",
                         test_name, run_cycle, exp_valid, exp_done, instr_valid, done);
            end
            if (exp_valid && instr_valid === 1'b1) begin
                e = {shadow_hi[8'(run_cycle - 3)], shadow_lo[8'(run_cycle - 3)]};
                compared++;
                if ({illegal, immediate, src_b, src_a, dest, opcode} !== decode_ref(e)) begin
                    data_errors++;
                    $display("Error %s entry %0d expected %h actual %h", test_name,
                             run_cycle - 3, decode_ref(e),
                             {illegal, immediate, src_b, src_a, dest, opcode});
                end
            end
            if (exp_done) begin
                active = 1'b0;
            end
            run_cycle++;
        end
    end

endmodule

//--- verification/fcore_istore_tb.sv
`timescale 1ns/1ps
`include "fcore_consts.svh"

module fcore_istore_tb;

    localparam int DEPTH = `ISTORE_DEPTH;
    localparam int LEN_W = $bits(istore_pkg::entry_addr_t) + 1;

    // Work done by the tests below
    localparam int PLANNED_WRITES = 2 * DEPTH + 16 + 16 + 23;
    localparam int PLANNED_FETCH  = DEPTH + 16 + 32 + 23 + 40 + 4 * 64;
    localparam int WATCHDOG_NS    = 40 * PLANNED_WRITES + 8 * PLANNED_FETCH + `WATCHDOG_BASE_NS;

    logic                   clock_in = 1'b0;
    logic                   reset_in;
    logic                   awvalid;
    istore_pkg::byte_addr_t awaddr;
    logic                   awready;
    logic                   wvalid;
    istore_pkg::axi_word_t  wdata;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   bready;
    logic                   run;
    logic [LEN_W-1:0]       program_length;
    logic                   instr_valid;
    isa_pkg::opcode_t       opcode;
    isa_pkg::reg_idx_t      dest;
    isa_pkg::reg_idx_t      src_a;
    isa_pkg::reg_idx_t      src_b;
    istore_pkg::axi_word_t  immediate;
    logic                   illegal;
    logic                   done;

    logic [15:0] lfsr_state    = 16'd63;
    int          writes_done   = 0;
    int          fetched_total = 0;

    always #2 clock_in = ~clock_in;  // 4 ns period

    fcore_istore_top dut (.*);

    fcore_istore_checker chk (.*);

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic start_test(input string name);
        chk.test_name = name;
        $display("Test %s", name);
    endtask

    task automatic axi_write(input int word_idx, input istore_pkg::axi_word_t data);
        int hold;
        hold = int'(take_bits(2));  // Cycles with bready low
        @(negedge clock_in);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = istore_pkg::byte_addr_t'(word_idx * 4);
        wdata   = data;
        @(negedge clock_in);
        while (awready !== 1'b1) begin
            @(negedge clock_in);
        end
        @(negedge clock_in);  // Handshake completed at the edge just passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (bvalid !== 1'b1) begin
            @(negedge clock_in);
        end
        repeat (hold) @(negedge clock_in);
        bready = 1'b1;
        @(negedge clock_in);
        bready = 1'b0;
        writes_done++;
    endtask

    // A second run pulse after extra_after cycles lands while the sequencer is busy
    task automatic run_program(input int length, input int extra_after);
        @(negedge clock_in);
        run            = 1'b1;
        program_length = LEN_W'(length);
        @(negedge clock_in);
        run = 1'b0;
        if (extra_after > 0) begin
            repeat (extra_after) @(negedge clock_in);
            run = 1'b1;
            @(negedge clock_in);
            run = 1'b0;
        end
        while (done !== 1'b1) begin
            @(negedge clock_in);
        end
        fetched_total += length;
        repeat (3) @(negedge clock_in);  // Room for anything trailing the done
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        istore_pkg::axi_word_t lo;
        istore_pkg::axi_word_t hi;
        int                    len;
        awvalid        = 1'b0;
        awaddr         = '0;
        wvalid         = 1'b0;
        wdata          = '0;
        bready         = 1'b0;
        run            = 1'b0;
        program_length = '0;
        reset_in       = 1'b0;
        repeat (5) @(posedge clock_in);
        @(negedge clock_in);
        reset_in = 1'b1;

        // Every 11-bit byte address falls inside the store, so all writes answer OKAY
        start_test("full_load");
        for (int e = 0; e < DEPTH; e++) begin
            lo      = take_bits(32);
            lo[4:0] = 5'(e % 9);  // All nine opcodes in turn
            hi      = take_bits(32);
            axi_write(2 * e, lo);
            axi_write(2 * e + 1, hi);
        end
        start_test("full_store_fetch");
        run_program(DEPTH, 0);

        start_test("low_half_rewrite");
        for (int e = 0; e < 16; e++) begin
            axi_write(2 * e, take_bits(32));
        end
        run_program(16, 0);

        start_test("high_half_rewrite");
        for (int e = 16; e < 32; e++) begin
            axi_write(2 * e + 1, take_bits(32));
        end
        run_program(32, 0);

        start_test("illegal_opcode");
        for (int e = 0; e < 23; e++) begin
            lo      = take_bits(32);
            lo[4:0] = 5'(9 + e);  // Encodings 9 to 31
            axi_write(2 * e, lo);
        end
        run_program(23, 0);

        start_test("run_while_busy");
        run_program(40, 10);

        start_test("zero_length");
        run_program(0, 0);

        start_test("random_length");
        repeat (4) begin
            len = 1 + int'(take_bits(6));
            run_program(len, 0);
        end

        if (chk.responses != writes_done) begin
            chk.flag_error($sformatf("%0d write responses seen for %0d writes",
                                     chk.responses, writes_done));
        end
        if (chk.compared != fetched_total) begin
            chk.flag_error($sformatf("%0d entries compared out of %0d fetched",
                                     chk.compared, fetched_total));
        end
        chk.report_counts();
        if (chk.total_errors() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
        chk.report_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verilog/fcore_consts.svh
`ifndef FCORE_CONSTS_SVH
`define FCORE_CONSTS_SVH

// Instruction store geometry, one entry is two bus words
`define ISTORE_DEPTH 256

// AXI4-Lite write port
`define AXI_DATA_WIDTH 32
`define AXI_ADDR_WIDTH 11  // 2 words x 256 entries x 4 bytes

// Register file index width
`define REG_ADDR_WIDTH 6

// Fixed watchdog allowance on top of the per-write and per-entry budget
`define WATCHDOG_BASE_NS 400

`endif

//--- verilog/fcore_istore_top.sv
`timescale 1ns/1ps
`include "fcore_consts.svh"

module fcore_istore_top (
    input  logic                                     clock_in,
    input  logic                                     reset_in,
    // AXI4-Lite write port
    input  logic                                     awvalid,
    input  istore_pkg::byte_addr_t                   awaddr,
    output logic                                     awready,
    input  logic                                     wvalid,
    input  istore_pkg::axi_word_t                    wdata,
    output logic                                     wready,
    output logic                                     bvalid,
    output logic [1:0]                               bresp,
    input  logic                                     bready,
    // Fetch control
    input  logic                                     run,
    input  logic [$bits(istore_pkg::entry_addr_t):0] program_length,
    // Decoded stream
    output logic                                     instr_valid,
    output isa_pkg::opcode_t                         opcode,
    output isa_pkg::reg_idx_t                        dest,
    output isa_pkg::reg_idx_t                        src_a,
    output isa_pkg::reg_idx_t                        src_b,
    output istore_pkg::axi_word_t                    immediate,
    output logic                                     illegal,
    output logic                                     done
);

    logic                    mem_we;
    istore_pkg::entry_addr_t mem_addr;
    logic                    mem_high;
    istore_pkg::axi_word_t   mem_wdata;

    logic                    fetch_valid;
    istore_pkg::entry_addr_t fetch_addr;
    logic                    last;
    logic                    last_q;    // Matches the store read latency

    istore_pkg::entry_t      entry;
    logic                    entry_valid;

    // ----------------------------------------
    // Load path
    // ----------------------------------------
    istore_axil_writer u_writer (
        .clock_in (clock_in),
        .reset_in (reset_in),
        .awvalid  (awvalid),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wdata    (wdata),
        .bready   (bready),
        .awready  (awready),
        .wready   (wready),
        .bvalid   (bvalid),
        .bresp    (bresp),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_high (mem_high),
        .mem_wdata(mem_wdata)
    );

    istore_memory #(
        .DEPTH(`ISTORE_DEPTH)
    ) u_memory (
        .clock_in   (clock_in),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_high   (mem_high),
        .mem_wdata  (mem_wdata),
        .fetch_valid(fetch_valid),
        .fetch_addr (fetch_addr),
        .entry      (entry),
        .entry_valid(entry_valid)
    );

    // ----------------------------------------
    // Fetch path
    // ----------------------------------------
    fetch_sequencer u_sequencer (
        .clock_in      (clock_in),
        .reset_in      (reset_in),
        .run           (run),
        .program_length(program_length),
        .fetch_valid   (fetch_valid),
        .fetch_addr    (fetch_addr),
        .last          (last)
    );

    always_ff @(posedge clock_in) begin
        if (!reset_in) begin
            last_q <= 1'b0;
        end else begin
            last_q <= last;
        end
    end

    instruction_decoder u_decoder (
        .clock_in   (clock_in),
        .reset_in   (reset_in),
        .entry      (entry),
        .entry_valid(entry_valid),
        .last_in    (last_q),
        .instr_valid(instr_valid),
        .opcode     (opcode),
        .dest       (dest),
        .src_a      (src_a),
        .src_b      (src_b),
        .immediate  (immediate),
        .illegal    (illegal),
        .done       (done)
    );

endmodule

//--- verilog/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer (
    input  logic                                     clock_in,
    input  logic                                     reset_in,
    input  logic                                     run,
    input  logic [$bits(istore_pkg::entry_addr_t):0] program_length,
    output logic                                     fetch_valid,
    output istore_pkg::entry_addr_t                  fetch_addr,
    output logic                                     last
);

    localparam int LEN_W = $bits(istore_pkg::entry_addr_t) + 1;

    logic                    busy_q;
    logic                    empty_q;   // Zero-length run, last without a fetch
    logic [LEN_W-1:0]        length_q;
    istore_pkg::entry_addr_t pc_q;
    logic                    at_end;

    assign at_end = LEN_W'(pc_q) == length_q - LEN_W'(1);

    assign fetch_valid = busy_q;
    assign fetch_addr  = pc_q;
    assign last        = (busy_q && at_end) || empty_q;

    always_ff @(posedge clock_in) begin
        if (!reset_in) begin
            busy_q  <= 1'b0;
            empty_q <= 1'b0;
            pc_q    <= '0;
        end else begin
            empty_q <= 1'b0;
            if (busy_q) begin
                pc_q <= pc_q + 1'b1;
                if (at_end) begin
                    busy_q <= 1'b0;
                end
            end else if (run && !empty_q) begin  // Runs while busy are dropped
                pc_q <= '0;
                if (program_length == '0) begin
                    empty_q <= 1'b1;
                end else begin
                    busy_q <= 1'b1;
                end
            end
        end
    end

    // Length captured at start
    always_ff @(posedge clock_in) begin
        if (run && !busy_q) begin
            length_q <= program_length;
        end
    end

endmodule

//--- verilog/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
    input  logic                  clock_in,
    input  logic                  reset_in,
    input  istore_pkg::entry_t    entry,
    input  logic                  entry_valid,
    input  logic                  last_in,
    output logic                  instr_valid,
    output isa_pkg::opcode_t      opcode,
    output isa_pkg::reg_idx_t     dest,
    output isa_pkg::reg_idx_t     src_a,
    output isa_pkg::reg_idx_t     src_b,
    output istore_pkg::axi_word_t immediate,
    output logic                  illegal,
    output logic                  done
);

    localparam int REG_W = $bits(isa_pkg::reg_idx_t);

    isa_pkg::opcode_t raw_op;
    logic             op_legal;

    assign raw_op = isa_pkg::opcode_t'(entry[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_WIDTH]);

    // Membership test against the enumeration
    always_comb begin
        case (raw_op)
            isa_pkg::OP_NOP, isa_pkg::OP_ADD, isa_pkg::OP_SUB,
            isa_pkg::OP_MUL, isa_pkg::OP_LDC, isa_pkg::OP_SHL,
            isa_pkg::OP_SHR, isa_pkg::OP_BGT, isa_pkg::OP_STOP: op_legal = 1'b1;
            default: op_legal = 1'b0;
        endcase
    end

    // ----------------------------------------
    // Field registers
    // ----------------------------------------
    always_ff @(posedge clock_in) begin
        if (entry_valid) begin
            opcode    <= raw_op;
            dest      <= entry[isa_pkg::DEST_LSB +: REG_W];
            src_a     <= entry[isa_pkg::SRC_A_LSB +: REG_W];
            src_b     <= entry[isa_pkg::SRC_B_LSB +: REG_W];
            immediate <= entry[isa_pkg::IMM_LSB +: isa_pkg::IMM_WIDTH];
            illegal   <= !op_legal;  // Other fields still decode
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_in) begin
            instr_valid <= 1'b0;
            done        <= 1'b0;
        end else begin
            instr_valid <= entry_valid;
            done        <= last_in;
        end
    end

endmodule

//--- verilog/isa_pkg.sv
`include "fcore_consts.svh"

package isa_pkg;

    localparam int OPCODE_WIDTH = 5;

    // Legal opcodes, every other encoding is illegal
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_NOP  = 5'd0,
        OP_ADD  = 5'd1,
        OP_SUB  = 5'd2,
        OP_MUL  = 5'd3,
        OP_LDC  = 5'd4,
        OP_SHL  = 5'd5,
        OP_SHR  = 5'd6,
        OP_BGT  = 5'd7,
        OP_STOP = 5'd8
    } opcode_t;

    typedef logic [`REG_ADDR_WIDTH-1:0] reg_idx_t;

    // ----------------------------------------
    // Entry layout, bits 31 to 23 reserved
    // ----------------------------------------
    localparam int OPCODE_LSB = 0;   // Bits 4..0
    localparam int DEST_LSB   = 5;   // Bits 10..5
    localparam int SRC_A_LSB  = 11;  // Bits 16..11
    localparam int SRC_B_LSB  = 17;  // Bits 22..17
    localparam int IMM_LSB    = 32;  // Whole high half
    localparam int IMM_WIDTH  = `AXI_DATA_WIDTH;

endpackage

//--- verilog/istore_axil_writer.sv
`timescale 1ns/1ps
`include "fcore_consts.svh"

module istore_axil_writer (
    input  logic                    clock_in,
    input  logic                    reset_in,
    input  logic                    awvalid,
    input  istore_pkg::byte_addr_t  awaddr,
    input  logic                    wvalid,
    input  istore_pkg::axi_word_t   wdata,
    input  logic                    bready,
    output logic                    awready,
    output logic                    wready,
    output logic                    bvalid,
    output logic [1:0]              bresp,
    output logic                    mem_we,
    output istore_pkg::entry_addr_t mem_addr,
    output logic                    mem_high,
    output istore_pkg::axi_word_t   mem_wdata
);

    localparam int WORD_IDX_WIDTH = `AXI_ADDR_WIDTH - 2;
    localparam int ENTRY_W        = $bits(istore_pkg::entry_addr_t);

    logic                      accept_q;   // Acceptance cycle, both readies high
    logic [WORD_IDX_WIDTH-1:0] word_idx;
    logic                      in_range;

    // ----------------------------------------
    // Address split
    // ----------------------------------------
    assign word_idx = awaddr[`AXI_ADDR_WIDTH-1:2];  // Byte offset dropped
    assign in_range = 32'(word_idx) < 2 * `ISTORE_DEPTH;

    // Master holds address and data until ready, so they feed the store directly
    assign mem_high  = word_idx[0];
    assign mem_addr  = word_idx[ENTRY_W:1];
    assign mem_wdata = wdata;
    assign mem_we    = accept_q && in_range;

    assign awready = accept_q;
    assign wready  = accept_q;

    // ----------------------------------------
    // Handshake and response
    // ----------------------------------------
    always_ff @(posedge clock_in) begin
        if (!reset_in) begin
            accept_q <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= istore_pkg::RESP_OKAY;
        end else begin
            // Both channels valid, nothing in flight
            accept_q <= awvalid && wvalid && !accept_q && !bvalid;

            if (accept_q) begin
                bvalid <= 1'b1;
                bresp  <= in_range ? istore_pkg::RESP_OKAY : istore_pkg::RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;  // Response taken
            end
        end
    end

endmodule

//--- verilog/istore_memory.sv
`timescale 1ns/1ps
`include "fcore_consts.svh"

module istore_memory #(
    parameter int DEPTH = `ISTORE_DEPTH
) (
    input  logic                    clock_in,
    input  logic                    mem_we,
    input  istore_pkg::entry_addr_t mem_addr,
    input  logic                    mem_high,
    input  istore_pkg::axi_word_t   mem_wdata,
    input  logic                    fetch_valid,
    input  istore_pkg::entry_addr_t fetch_addr,
    output istore_pkg::entry_t      entry,
    output logic                    entry_valid
);

    localparam int WORD_W = $bits(istore_pkg::axi_word_t);

    // One bank per half so a single bus word never touches the other half
    for (genvar b = 0; b < 2; b++) begin : g_bank
        localparam bit HIGH = (b == 1);

        istore_pkg::axi_word_t bank [DEPTH];
        istore_pkg::axi_word_t rd_word;

        always_ff @(posedge clock_in) begin
            if (mem_we && (mem_high == HIGH)) begin
                bank[mem_addr] <= mem_wdata;
            end
            if (fetch_valid) begin
                rd_word <= bank[fetch_addr];  // Synchronous read
            end
        end

        assign entry[b*WORD_W +: WORD_W] = rd_word;
    end

    // Valid follows the read latency
    always_ff @(posedge clock_in) begin
        entry_valid <= fetch_valid;
    end

endmodule

//--- verilog/istore_pkg.sv
`include "fcore_consts.svh"

package istore_pkg;

    // ----------------------------------------
    // Bus side
    // ----------------------------------------
    typedef logic [`AXI_DATA_WIDTH-1:0] axi_word_t;
    typedef logic [`AXI_ADDR_WIDTH-1:0] byte_addr_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ----------------------------------------
    // Store side
    // ----------------------------------------
    typedef logic [$clog2(`ISTORE_DEPTH)-1:0] entry_addr_t;

    // Low word from the even address, high word from the odd one
    typedef logic [2*`AXI_DATA_WIDTH-1:0] entry_t;

endpackage
